//--- verification/excp_golden.txt
# test ti ti_clr swi swi_clr hwi req excp code ertn badv epc csr_op csr_addr wdata (hex)
# expected: redirect_valid redirect_pc flush clr_idle_stall int_status csr_rdata (hex)
1 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 8
1 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 1 5 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 1 c 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 2 4 1fff 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 1 4 0 0 0 0 0 0 bff
1 0 0 0 0 0 0 0 0 0 0 0 2 c 1c00807f 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 1 c 0 0 0 0 0 0 1c008040
1 0 0 0 0 0 0 0 0 0 0 0 2 88 1c00f0ff 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 1 88 0 0 0 0 0 0 1c00f0c0
2 0 0 0 0 0 0 0 0 0 0 0 2 0 17 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 17
2 0 0 0 0 0 1 1 b 0 deadbeef 1c000100 1 0 0 1 1c008040 1 0 0 17
2 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 10
2 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0 0 0 0 7
2 0 0 0 0 0 0 0 0 0 0 0 1 6 0 0 0 0 0 0 1c000100
2 0 0 0 0 0 0 0 0 0 0 0 1 5 0 0 0 0 0 0 b0000
2 0 0 0 0 0 0 0 0 0 0 0 1 7 0 0 0 0 0 0 0
2 0 0 0 0 0 1 1 9 0 12345679 1c000200 1 1 0 1 1c008040 1 0 0 7
2 0 0 0 0 0 0 0 0 0 0 0 1 7 0 0 0 0 0 0 12345679
2 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 1 5 0 0 0 0 0 0 90000
3 0 0 0 0 0 1 1 3f 0 87654321 1c000300 1 6 0 1 1c00f0c0 1 0 0 1c000200
3 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 8
3 0 0 0 0 0 0 0 0 0 0 0 1 7 0 0 0 0 0 0 87654321
3 0 0 0 0 0 0 0 0 0 0 0 1 11 0 0 0 0 0 0 87654000
3 0 0 0 0 0 0 0 0 0 0 0 1 5 0 0 0 0 0 0 3f0000
4 0 0 2 0 0 0 0 0 0 0 0 2 0 4 0 0 0 0 0 0
4 0 0 0 0 0 0 0 0 0 0 0 2 4 1 0 0 0 0 0 0
4 0 0 0 0 0 1 0 0 0 0 1c000380 1 5 0 0 0 0 0 2 3f0002
4 0 0 0 0 0 0 0 0 0 0 0 2 4 2 0 0 0 0 2 0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 2 0
4 0 0 0 0 0 1 0 0 0 0 1c000400 1 0 0 1 1c008040 1 1 2 4
4 0 0 0 0 0 0 0 0 0 0 0 1 5 0 0 0 0 0 2 2
4 0 0 0 2 0 0 0 0 0 0 0 1 1 0 0 0 0 0 2 4
4 0 0 0 0 0 0 0 0 0 0 0 1 6 0 0 0 0 0 2 1c000400
4 0 0 0 0 0 0 0 0 0 0 0 1 5 0 0 0 0 0 0 0
5 1 0 0 0 0 0 0 0 0 0 0 2 0 7 0 0 0 0 0 0
5 0 0 0 0 0 0 0 0 0 0 0 2 4 800 0 0 0 0 0 0
5 0 0 0 0 0 1 1 9 0 55555555 1c000500 1 0 0 1 1c008040 1 1 800 7
5 0 0 0 0 0 0 0 0 0 0 0 1 5 0 0 0 0 0 800 800
5 0 1 0 0 0 0 0 0 0 0 0 1 7 0 0 0 0 0 800 87654321
5 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 0 0 0 800 7
6 0 0 0 0 0 1 0 0 1 0 0 1 6 0 1 1c000500 0 0 0 1c000500
6 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 7

//--- excp_top.f
+incdir+verilog
verilog/excp_pkg.sv
verilog/int_pending.sv
verilog/excp_unit.sv
verilog/csr_file.sv
verilog/excp_top.sv
verification/excp_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the excp_top testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module excp_tb \
    -f excp_top.f

./obj_dir/Vexcp_tb > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without a reported failure"

//--- verification/excp_tb.sv
`timescale 1ns/1ps
`include "excp_cfg.svh"

module excp_tb
    import excp_pkg::*;
();

    localparam int CLK_PERIOD  = 20;
    localparam int RST_CYCLES  = 10;
    localparam int NUM_RECORDS = 45;
    localparam int MAX_CYCLES  = NUM_RECORDS + RST_CYCLES + 50;
    localparam int NUM_FIELDS  = 21;

    logic                     clk;
    logic                     rst_n;
    logic                     ti_in;
    logic                     ti_clr;
    logic [1:0]               swi_in;
    logic [1:0]               swi_clr;
    logic [7:0]               hwi_in;
    logic                     req_valid;
    logic                     excp_valid;
    esubcode_ecode_t          excp_code;
    logic [`EXCP_XLEN-1:0]    excp_badv;
    logic [`EXCP_XLEN-1:0]    epc;
    logic                     ertn;
    csr_op_t                  csr_op;
    logic [`CSR_ADDR_W-1:0]   csr_addr;
    logic [`EXCP_XLEN-1:0]    csr_wdata;
    logic [`EXCP_XLEN-1:0]    csr_rdata;
    logic                     redirect_valid;
    logic [`EXCP_XLEN-1:0]    redirect_pc;
    logic                     excp_flush;
    logic                     clr_idle_stall;
    logic [`EXCP_NUM_INT-1:0] int_status;

    // One golden record, columns in file order.
    logic [31:0]              rec [NUM_FIELDS];
    logic [8*160-1:0]         text_line;
    int                       fd;
    int                       nread;
    int                       cycles = 0;
    int                       cur_test = 0;
    int                       test_errs = 0;
    int                       tests_passed = 0;
    int                       tests_failed = 0;
    int                       file_errs = 0;
    int                       num_run = 0;

    excp_top UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .ti_in          (ti_in),
        .ti_clr         (ti_clr),
        .swi_in         (swi_in),
        .swi_clr        (swi_clr),
        .hwi_in         (hwi_in),
        .req_valid      (req_valid),
        .excp_valid     (excp_valid),
        .excp_code      (excp_code),
        .excp_badv      (excp_badv),
        .epc            (epc),
        .ertn           (ertn),
        .csr_op         (csr_op),
        .csr_addr       (csr_addr),
        .csr_wdata      (csr_wdata),
        .csr_rdata      (csr_rdata),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .excp_flush     (excp_flush),
        .clr_idle_stall (clr_idle_stall),
        .int_status     (int_status)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Run limit.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, golden file not finished", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic compare_value(input logic [31:0] got, input logic [31:0] want,
                                 input string what);
        if (got !== want) begin
            $display("FAIL %0t: test %0d %s is %h, expected %h",
                     $time, cur_test, what, got, want);
            test_errs++;
        end
    endtask

    task automatic report_test(input int num);
        if (test_errs == 0) begin
            $display("Test %0d: PASS", num);
            tests_passed++;
        end else begin
            $display("Test %0d: FAIL with %0d mismatches", num, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Drive one cycle, check before next edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic apply_record();
        @(posedge clk);
        ti_in      <= rec[1][0];
        ti_clr     <= rec[2][0];
        swi_in     <= rec[3][1:0];
        swi_clr    <= rec[4][1:0];
        hwi_in     <= rec[5][7:0];
        req_valid  <= rec[6][0];
        excp_valid <= rec[7][0];
        excp_code  <= esubcode_ecode_t'(rec[8][14:0]);
        ertn       <= rec[9][0];
        excp_badv  <= rec[10];
        epc        <= rec[11];
        csr_op     <= csr_op_t'(rec[12][1:0]);
        csr_addr   <= rec[13][`CSR_ADDR_W-1:0];
        csr_wdata  <= rec[14];
    endtask

    task automatic check_outputs();
        compare_value(32'(redirect_valid), rec[15], "redirect_valid");
        // Target only matters with a redirect.
        if (rec[15][0]) begin
            compare_value(redirect_pc, rec[16], "redirect_pc");
        end
        compare_value(32'(excp_flush), rec[17], "excp_flush");
        compare_value(32'(clr_idle_stall), rec[18], "clr_idle_stall");
        compare_value(32'(int_status), rec[19], "int_status");
        compare_value(csr_rdata, rec[20], "csr_rdata");
    endtask

    initial begin
        rst_n      = 1'b0;
        ti_in      = 1'b0;
        ti_clr     = 1'b0;
        swi_in     = 2'b0;
        swi_clr    = 2'b0;
        hwi_in     = 8'b0;
        req_valid  = 1'b0;
        excp_valid = 1'b0;
        excp_code  = INT;
        excp_badv  = '0;
        epc        = '0;
        ertn       = 1'b0;
        csr_op     = CSR_NONE;
        csr_addr   = '0;
        csr_wdata  = '0;
        fd = $fopen("verification/excp_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open golden file verification/excp_golden.txt");
            file_errs++;
        end
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        if (fd != 0) begin
            while ($fgets(text_line, fd) != 0) begin
                nread = $sscanf(text_line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    rec[0], rec[1], rec[2], rec[3], rec[4], rec[5], rec[6],
                    rec[7], rec[8], rec[9], rec[10], rec[11], rec[12], rec[13],
                    rec[14], rec[15], rec[16], rec[17], rec[18], rec[19], rec[20]);
                // Comment and blank lines scan no fields.
                if (nread > 0 && nread < NUM_FIELDS) begin
                    $display("Short record in golden file, %0d of %0d fields read",
                             nread, NUM_FIELDS);
                    file_errs++;
                end else if (nread == NUM_FIELDS) begin
                    if (cur_test != 0 && int'(rec[0]) != cur_test) begin
                        report_test(cur_test);
                    end
                    cur_test = int'(rec[0]);
                    num_run++;
                    apply_record();
                    #(CLK_PERIOD - 1);
                    check_outputs();
                end
            end
            $fclose(fd);
        end
        if (cur_test != 0) begin
            report_test(cur_test);
        end
        if (fd != 0 && num_run == 0) begin
            $display("Golden file holds no records");
            file_errs++;
        end
        $display("Tests passed: %0d, tests failed: %0d, file errors: %0d",
                 tests_passed, tests_failed, file_errs);
        if (tests_failed == 0 && file_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- verilog/excp_top.sv
`timescale 1ns/1ps
`include "excp_cfg.svh"

module excp_top import excp_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,

    // Interrupt sources.
    input  logic                     ti_in,
    input  logic                     ti_clr,
    input  logic [1:0]               swi_in,
    input  logic [1:0]               swi_clr,
    input  logic [7:0]               hwi_in,

    // Commit request.
    input  logic                     req_valid,
    input  logic                     excp_valid,
    input  esubcode_ecode_t          excp_code,
    input  logic [`EXCP_XLEN-1:0]    excp_badv,
    input  logic [`EXCP_XLEN-1:0]    epc,
    input  logic                     ertn,

    // Software CSR access.
    input  csr_op_t                  csr_op,
    input  logic [`CSR_ADDR_W-1:0]   csr_addr,
    input  logic [`EXCP_XLEN-1:0]    csr_wdata,
    output logic [`EXCP_XLEN-1:0]    csr_rdata,

    output logic                     redirect_valid,
    output logic [`EXCP_XLEN-1:0]    redirect_pc,
    output logic                     excp_flush,
    output logic                     clr_idle_stall,
    output logic [`EXCP_NUM_INT-1:0] int_status
);

    plv_t                     crmd_plv;
    logic                     crmd_ie;
    logic                     crmd_da;
    logic                     crmd_pg;
    plv_t                     prmd_pplv;
    logic                     prmd_pie;
    logic [`EXCP_NUM_INT-1:0] ecfg_lie;
    logic [`EXCP_XLEN-1:0]    era;
    logic [`EXCP_XLEN-1:0]    badv;
    logic [`EXCP_VPPN_W-1:0]  tlbehi_vppn;
    esubcode_ecode_t          estat_code;
    logic [`EXCP_XLEN-1:0]    eentry;
    logic [`EXCP_XLEN-1:0]    tlbrentry;

    logic                     upd_we;
    plv_t                     upd_plv;
    logic                     upd_ie;
    logic                     upd_da;
    logic                     upd_pg;
    plv_t                     upd_pplv;
    logic                     upd_pie;
    logic [`EXCP_XLEN-1:0]    upd_era;
    esubcode_ecode_t          upd_code;
    logic [`EXCP_XLEN-1:0]    upd_badv;
    logic [`EXCP_VPPN_W-1:0]  upd_vppn;

    int_pending u_int_pending (
        .clk        (clk),
        .rst_n      (rst_n),
        .ti_in      (ti_in),
        .ti_clr     (ti_clr),
        .swi_in     (swi_in),
        .swi_clr    (swi_clr),
        .hwi_in     (hwi_in),
        .int_status (int_status)
    );

    excp_unit u_excp_unit (
        .req_valid      (req_valid),
        .excp_valid     (excp_valid),
        .excp_code      (excp_code),
        .excp_badv      (excp_badv),
        .epc            (epc),
        .ertn           (ertn),
        .int_status     (int_status),
        .crmd_plv       (crmd_plv),
        .crmd_ie        (crmd_ie),
        .crmd_da        (crmd_da),
        .crmd_pg        (crmd_pg),
        .prmd_pplv      (prmd_pplv),
        .prmd_pie       (prmd_pie),
        .ecfg_lie       (ecfg_lie),
        .era            (era),
        .badv           (badv),
        .tlbehi_vppn    (tlbehi_vppn),
        .estat_code     (estat_code),
        .eentry         (eentry),
        .tlbrentry      (tlbrentry),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .excp_flush     (excp_flush),
        .clr_idle_stall (clr_idle_stall),
        .upd_we         (upd_we),
        .upd_plv        (upd_plv),
        .upd_ie         (upd_ie),
        .upd_da         (upd_da),
        .upd_pg         (upd_pg),
        .upd_pplv       (upd_pplv),
        .upd_pie        (upd_pie),
        .upd_era        (upd_era),
        .upd_code       (upd_code),
        .upd_badv       (upd_badv),
        .upd_vppn       (upd_vppn)
    );

    csr_file u_csr_file (
        .clk         (clk),
        .rst_n       (rst_n),
        .csr_op      (csr_op),
        .csr_addr    (csr_addr),
        .csr_wdata   (csr_wdata),
        .csr_rdata   (csr_rdata),
        .int_status  (int_status),
        .upd_we      (upd_we),
        .upd_plv     (upd_plv),
        .upd_ie      (upd_ie),
        .upd_da      (upd_da),
        .upd_pg      (upd_pg),
        .upd_pplv    (upd_pplv),
        .upd_pie     (upd_pie),
        .upd_era     (upd_era),
        .upd_code    (upd_code),
        .upd_badv    (upd_badv),
        .upd_vppn    (upd_vppn),
        .crmd_plv    (crmd_plv),
        .crmd_ie     (crmd_ie),
        .crmd_da     (crmd_da),
        .crmd_pg     (crmd_pg),
        .prmd_pplv   (prmd_pplv),
        .prmd_pie    (prmd_pie),
        .ecfg_lie    (ecfg_lie),
        .era         (era),
        .badv        (badv),
        .tlbehi_vppn (tlbehi_vppn),
        .estat_code  (estat_code),
        .eentry      (eentry),
        .tlbrentry   (tlbrentry)
    );

endmodule

//--- verilog/csr_file.sv
`timescale 1ns/1ps
`include "excp_cfg.svh"

module csr_file import excp_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,

    // Software access.
    input  csr_op_t                  csr_op,
    input  logic [`CSR_ADDR_W-1:0]   csr_addr,
    input  logic [`EXCP_XLEN-1:0]    csr_wdata,
    output logic [`EXCP_XLEN-1:0]    csr_rdata,

    input  logic [`EXCP_NUM_INT-1:0] int_status,

    // Exception update.
    input  logic                     upd_we,
    input  plv_t                     upd_plv,
    input  logic                     upd_ie,
    input  logic                     upd_da,
    input  logic                     upd_pg,
    input  plv_t                     upd_pplv,
    input  logic                     upd_pie,
    input  logic [`EXCP_XLEN-1:0]    upd_era,
    input  esubcode_ecode_t          upd_code,
    input  logic [`EXCP_XLEN-1:0]    upd_badv,
    input  logic [`EXCP_VPPN_W-1:0]  upd_vppn,

    // Current fields.
    output plv_t                     crmd_plv,
    output logic                     crmd_ie,
    output logic                     crmd_da,
    output logic                     crmd_pg,
    output plv_t                     prmd_pplv,
    output logic                     prmd_pie,
    output logic [`EXCP_NUM_INT-1:0] ecfg_lie,
    output logic [`EXCP_XLEN-1:0]    era,
    output logic [`EXCP_XLEN-1:0]    badv,
    output logic [`EXCP_VPPN_W-1:0]  tlbehi_vppn,
    output esubcode_ecode_t          estat_code,
    output logic [`EXCP_XLEN-1:0]    eentry,
    output logic [`EXCP_XLEN-1:0]    tlbrentry
);

    logic                         sw_we;
    logic [`EXCP_XLEN-1:0]        entry_wdata;

    assign sw_we = (csr_op == CSR_WRITE);

    // Entry vectors drop the low alignment bits.
    assign entry_wdata = {csr_wdata[`EXCP_XLEN-1:`EXCP_ENTRY_ALIGN],
                          {`EXCP_ENTRY_ALIGN{1'b0}}};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register update.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crmd_plv    <= KERNEL;
            crmd_ie     <= 1'b0;
            crmd_da     <= 1'b1;
            crmd_pg     <= 1'b0;
            prmd_pplv   <= KERNEL;
            prmd_pie    <= 1'b0;
            ecfg_lie    <= '0;
            estat_code  <= INT;
            era         <= '0;
            badv        <= '0;
            tlbehi_vppn <= '0;
            eentry      <= '0;
            tlbrentry   <= '0;
        end else begin
            if (sw_we) begin
                case (csr_addr)
                    `CSR_CRMD: begin
                        crmd_plv <= plv_t'(csr_wdata[1:0]);
                        crmd_ie  <= csr_wdata[2];
                        crmd_da  <= csr_wdata[3];
                        crmd_pg  <= csr_wdata[4];
                    end
                    `CSR_PRMD: begin
                        prmd_pplv <= plv_t'(csr_wdata[1:0]);
                        prmd_pie  <= csr_wdata[2];
                    end
                    `CSR_ECFG:      ecfg_lie    <= csr_wdata[`EXCP_NUM_INT-1:0] & `EXCP_INT_MASK;
                    `CSR_ERA:       era         <= csr_wdata;
                    `CSR_BADV:      badv        <= csr_wdata;
                    `CSR_TLBEHI:    tlbehi_vppn <= csr_wdata[`EXCP_XLEN-1:`EXCP_VPPN_LSB];
                    `CSR_EENTRY:    eentry      <= entry_wdata;
                    `CSR_TLBRENTRY: tlbrentry   <= entry_wdata;
                    default: ;
                endcase
            end
            // Exception update overrides a same-cycle software write.
            if (upd_we) begin
                crmd_plv    <= upd_plv;
                crmd_ie     <= upd_ie;
                crmd_da     <= upd_da;
                crmd_pg     <= upd_pg;
                prmd_pplv   <= upd_pplv;
                prmd_pie    <= upd_pie;
                era         <= upd_era;
                estat_code  <= upd_code;
                badv        <= upd_badv;
                tlbehi_vppn <= upd_vppn;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read mux.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        csr_rdata = '0;
        if (csr_op == CSR_READ) begin
            case (csr_addr)
                `CSR_CRMD:      csr_rdata = {27'b0, crmd_pg, crmd_da, crmd_ie, crmd_plv};
                `CSR_PRMD:      csr_rdata = {29'b0, prmd_pie, prmd_pplv};
                `CSR_ECFG:      csr_rdata = {19'b0, ecfg_lie};
                // Status bits come live from the pending latch.
                `CSR_ESTAT:     csr_rdata = {1'b0, estat_code, 3'b0, int_status};
                `CSR_ERA:       csr_rdata = era;
                `CSR_BADV:      csr_rdata = badv;
                `CSR_EENTRY:    csr_rdata = eentry;
                `CSR_TLBEHI:    csr_rdata = {tlbehi_vppn, {`EXCP_VPPN_LSB{1'b0}}};
                `CSR_TLBRENTRY: csr_rdata = tlbrentry;
                default:        csr_rdata = '0;
            endcase
        end
    end

    a_csr_op_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(csr_op))
        else $error("csr_op is unknown");

    // Holds across both the software and the reset path.
    a_eentry_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        eentry[`EXCP_ENTRY_ALIGN-1:0] == '0)
        else $error("eentry low bits not zero");

endmodule

//--- verilog/excp_unit.sv
`timescale 1ns/1ps
`include "excp_cfg.svh"

module excp_unit import excp_pkg::*; (
    // Commit request.
    input  logic                     req_valid,
    input  logic                     excp_valid,
    input  esubcode_ecode_t          excp_code,
    input  logic [`EXCP_XLEN-1:0]    excp_badv,
    input  logic [`EXCP_XLEN-1:0]    epc,
    input  logic                     ertn,
    input  logic [`EXCP_NUM_INT-1:0] int_status,

    // Current CSR fields.
    input  plv_t                     crmd_plv,
    input  logic                     crmd_ie,
    input  logic                     crmd_da,
    input  logic                     crmd_pg,
    input  plv_t                     prmd_pplv,
    input  logic                     prmd_pie,
    input  logic [`EXCP_NUM_INT-1:0] ecfg_lie,
    input  logic [`EXCP_XLEN-1:0]    era,
    input  logic [`EXCP_XLEN-1:0]    badv,
    input  logic [`EXCP_VPPN_W-1:0]  tlbehi_vppn,
    input  esubcode_ecode_t          estat_code,
    input  logic [`EXCP_XLEN-1:0]    eentry,
    input  logic [`EXCP_XLEN-1:0]    tlbrentry,

    // Redirect and control.
    output logic                     redirect_valid,
    output logic [`EXCP_XLEN-1:0]    redirect_pc,
    output logic                     excp_flush,
    output logic                     clr_idle_stall,

    // CSR update.
    output logic                     upd_we,
    output plv_t                     upd_plv,
    output logic                     upd_ie,
    output logic                     upd_da,
    output logic                     upd_pg,
    output plv_t                     upd_pplv,
    output logic                     upd_pie,
    output logic [`EXCP_XLEN-1:0]    upd_era,
    output esubcode_ecode_t          upd_code,
    output logic [`EXCP_XLEN-1:0]    upd_badv,
    output logic [`EXCP_VPPN_W-1:0]  upd_vppn
);

    logic int_pend;
    logic take_int;
    logic take_excp;
    logic take_ertn;
    logic is_tlbr;
    logic wr_badv;
    logic wr_vppn;

    assign int_pend  = crmd_ie & (|(int_status & ecfg_lie));
    // A bubble never takes an interrupt.
    assign take_int  = req_valid & int_pend;
    assign take_excp = ~take_int & excp_valid;
    assign take_ertn = ~take_int & ~excp_valid & req_valid & ertn;

    // Wake an idle core whether or not an instruction commits.
    assign clr_idle_stall = int_pend;

    assign is_tlbr = (excp_code == TLBR);
    assign wr_vppn = is_tlbr || (excp_code == PIL) || (excp_code == PIS) ||
                     (excp_code == PIF) || (excp_code == PME) || (excp_code == PPI);
    assign wr_badv = wr_vppn || (excp_code == ADEF) || (excp_code == ADEM) ||
                     (excp_code == ALE);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Redirect.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign excp_flush     = take_int | take_excp;
    assign redirect_valid = excp_flush | take_ertn;

    always_comb begin
        if (take_ertn) begin
            redirect_pc = era;
        end else if (take_excp && is_tlbr) begin
            redirect_pc = tlbrentry;
        end else begin
            redirect_pc = eentry;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CSR update.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        // Raised by any request, ahead of the priority chain.
        upd_we   = (req_valid & (int_pend | ertn)) | excp_valid;
        upd_plv  = crmd_plv;
        upd_ie   = crmd_ie;
        upd_da   = crmd_da;
        upd_pg   = crmd_pg;
        upd_pplv = prmd_pplv;
        upd_pie  = prmd_pie;
        upd_era  = era;
        upd_code = estat_code;
        upd_badv = badv;
        upd_vppn = tlbehi_vppn;
        if (take_int || take_excp) begin
            upd_pplv = crmd_plv;
            upd_pie  = crmd_ie;
            upd_plv  = KERNEL;
            upd_ie   = 1'b0;
            upd_era  = epc;
            upd_code = take_int ? INT : excp_code;
        end
        if (take_excp) begin
            // Refill runs in direct address mode.
            if (is_tlbr) begin
                upd_da = 1'b1;
                upd_pg = 1'b0;
            end
            if (wr_badv) begin
                upd_badv = excp_badv;
            end
            if (wr_vppn) begin
                upd_vppn = excp_badv[`EXCP_XLEN-1:`EXCP_VPPN_LSB];
            end
        end
        if (take_ertn) begin
            upd_plv = prmd_pplv;
            upd_ie  = prmd_pie;
        end
    end

    // Every CSR update must come with a pipeline redirect.
    always_comb begin
        a_upd_has_redirect: assert (!upd_we || redirect_valid)
            else $error("CSR update without redirect");
    end

endmodule

//--- verilog/int_pending.sv
`timescale 1ns/1ps
`include "excp_cfg.svh"

module int_pending (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     ti_in,
    input  logic                     ti_clr,
    input  logic [1:0]               swi_in,
    input  logic [1:0]               swi_clr,
    input  logic [7:0]               hwi_in,
    output logic [`EXCP_NUM_INT-1:0] int_status
);

    logic [`EXCP_NUM_INT-1:0] int_vec;
    logic [`EXCP_NUM_INT-1:0] int_clr;
    logic [`EXCP_NUM_INT-1:0] latch_q;
    logic [`EXCP_NUM_INT-1:0] status_q;

    // No IPI, bits 10 and 12 stay zero.
    assign int_vec = {1'b0, ti_in, 1'b0, hwi_in, swi_in};

    // Hardware lines are held by their source.
    assign int_clr = {1'b0, ti_clr, 1'b0, 8'b0, swi_clr};

    // Sticky first stage.
    // Clear beats a new request in the same cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            latch_q <= '0;
        end else begin
            latch_q <= ~int_clr & (int_vec | latch_q);
        end
    end

    // Second stage.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_q <= '0;
        end else begin
            status_q <= latch_q;
        end
    end

    assign int_status = status_q;

endmodule

//--- verilog/excp_pkg.sv
package excp_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Exception codes as {esubcode, ecode}.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [14:0] {
        INT  = 15'h0000,
        PIL  = 15'h0001,
        PIS  = 15'h0002,
        PIF  = 15'h0003,
        PME  = 15'h0004,
        PPI  = 15'h0007,
        ADEF = 15'h0008,
        // Same ecode as ADEF, esubcode 1.
        ADEM = 15'h0048,
        ALE  = 15'h0009,
        SYS  = 15'h000B,
        BRK  = 15'h000C,
        INE  = 15'h000D,
        TLBR = 15'h003F
    } esubcode_ecode_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Privilege levels.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        KERNEL = 2'd0,
        USER   = 2'd3
    } plv_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Software CSR access.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_READ  = 2'd1,
        CSR_WRITE = 2'd2
    } csr_op_t;

endpackage

//--- verilog/excp_cfg.svh
`ifndef EXCP_CFG_SVH
`define EXCP_CFG_SVH

// Data and address width.
`define EXCP_XLEN 32

// Interrupt vector width. Bits 10 and 12 are tied off.
`define EXCP_NUM_INT 13
`define EXCP_INT_MASK 13'h0BFF

// Entry vectors are aligned to 64 bytes.
`define EXCP_ENTRY_ALIGN 6

// Virtual page pair number in TLBEHI.
`define EXCP_VPPN_LSB 13
`define EXCP_VPPN_W 19

// CSR address map.
`define CSR_ADDR_W 14
`define CSR_CRMD 14'h000
`define CSR_PRMD 14'h001
`define CSR_ECFG 14'h004
`define CSR_ESTAT 14'h005
`define CSR_ERA 14'h006
`define CSR_BADV 14'h007
`define CSR_EENTRY 14'h00C
`define CSR_TLBEHI 14'h011
`define CSR_TLBRENTRY 14'h088

`endif
